// ==== Bender.yml ====
package:
  name: rv32v_memory_subsystem

sources:
  - files:
      - source/rv32v_mem_pkg.sv
      - source/address_scheduler.sv
      - source/rv32v_memory_stage.sv
      - source/data_ram.sv
      - source/rv32v_memory_subsystem.sv
  - target: test
    include_dirs:
      - tests
    files:
      - tests/tb_rv32v_memory_subsystem.sv

// ==== files.f ====
+incdir+tests
source/rv32v_mem_pkg.sv
source/address_scheduler.sv
source/rv32v_memory_stage.sv
source/data_ram.sv
source/rv32v_memory_subsystem.sv
tests/tb_rv32v_memory_subsystem.sv

// ==== source/address_scheduler.sv ====
// Serializes two lanes onto one data port; upstream must hold all inputs while busy is high
module address_scheduler
  import rv32v_mem_pkg::*;
(
  input  logic         CLK,
  input  logic         nRST,
  input  logic         start,
  input  logic         load_ena,
  input  logic         store_ena,
  input  eew_t         eew,
  input  logic [1:0]   lane_wen,
  input  word_t        addr0,
  input  word_t        addr1,
  input  word_t        storedata0,
  input  word_t        storedata1,
  input  logic         dhit,
  output logic         ren,
  output logic         wen,
  output byte_ena_t    byte_ena,
  output word_t        final_addr,
  output word_t        final_storedata,
  output logic         arrived0,
  output logic         busy,
  output logic         exception
);

  sched_state_t state, next_state;

  logic  in_lane;
  logic  mis0;
  logic  mis1;
  logic  accept;
  word_t lane_addr;
  word_t lane_data;

  // Byte enables from element width and byte offset
  function automatic byte_ena_t lane_byte_ena(eew_t e, logic [1:0] off);
    byte_ena_t be;
    case (e)
      2'd0:    be = 4'b0001 << off;
      2'd1:    be = off[1] ? 4'b1100 : 4'b0011;
      default: be = 4'b1111;
    endcase
    return be;
  endfunction

  // Replicate the element into every byte slot it may land in
  function automatic word_t lane_store(eew_t e, word_t d);
    word_t w;
    case (e)
      2'd0:    w = {4{d[7:0]}};
      2'd1:    w = {2{d[15:0]}};
      default: w = d;
    endcase
    return w;
  endfunction

  function automatic logic lane_misaligned(eew_t e, logic [1:0] off);
    logic bad;
    case (e)
      2'd0:    bad = 1'b0;
      2'd1:    bad = off[0];
      default: bad = (off != 2'b00);
    endcase
    return bad;
  endfunction

  // Only active lanes can fault
  assign mis0 = lane_wen[0] && lane_misaligned(eew, addr0[1:0]);
  assign mis1 = lane_wen[1] && lane_misaligned(eew, addr1[1:0]);

  assign exception = (state == IDLE) && start && (mis0 || mis1);
  assign accept    = (state == IDLE) && start && !(mis0 || mis1);

  always_ff @(posedge CLK, negedge nRST) begin
    if (!nRST) begin
      state <= IDLE;
    end else begin
      state <= next_state;
    end
  end

  always_comb begin
    next_state = state;
    case (state)
      IDLE: begin
        if (accept) begin
          if (lane_wen[0]) begin
            next_state = LANE0;
          end else if (lane_wen[1]) begin
            next_state = LANE1;
          end else begin
            next_state = DONE;
          end
        end
      end
      LANE0: begin
        if (dhit) begin
          next_state = lane_wen[1] ? LANE1 : IDLE;
        end
      end
      LANE1: begin
        if (dhit) begin
          next_state = IDLE;
        end
      end
      DONE: begin
        next_state = IDLE;
      end
      default: begin
        next_state = IDLE;
      end
    endcase
  end

  // Busy drops in the cycle of the last hit so the stage latches then
  always_comb begin
    case (state)
      IDLE:    busy = accept;
      LANE0:   busy = !(dhit && !lane_wen[1]);
      LANE1:   busy = !dhit;
      default: busy = 1'b0;
    endcase
  end

  assign in_lane  = (state == LANE0) || (state == LANE1);
  assign arrived0 = (state == LANE0) && dhit;

  assign lane_addr = (state == LANE1) ? addr1 : addr0;
  assign lane_data = (state == LANE1) ? storedata1 : storedata0;

  // Load wins if both enables are set
  assign ren = in_lane && load_ena;
  assign wen = in_lane && store_ena && !load_ena;

  assign byte_ena        = lane_byte_ena(eew, lane_addr[1:0]);
  assign final_addr      = {lane_addr[31:2], 2'b00};
  assign final_storedata = lane_store(eew, lane_data);

endmodule

// ==== source/data_ram.sv ====
// Data cache stand-in; only address bits [9:2] select a word and a request must stay up until dhit
module data_ram
  import rv32v_mem_pkg::*;
(
  input  logic       CLK,
  input  logic       nRST,
  input  logic       ren,
  input  logic       wen,
  input  byte_ena_t  byte_ena,
  input  word_t      addr,
  input  word_t      wdata,
  output word_t      rdata,
  output logic       dhit
);

  word_t mem [RAM_WORDS];

  logic [DHIT_CNT_W-1:0] cnt;
  logic [RAM_AW-1:0]     word_idx;
  logic                  req;

  assign req      = ren || wen;
  assign word_idx = addr[RAM_AW+1:2];

  // Starts from zero in simulation
  initial begin
    for (int i = 0; i < RAM_WORDS; i++) begin
      mem[i] = '0;
    end
  end

  // Restarts after each hit so a held request begins a new access
  always_ff @(posedge CLK, negedge nRST) begin
    if (!nRST) begin
      cnt <= '0;
    end else if (!req || dhit) begin
      cnt <= '0;
    end else begin
      cnt <= cnt + 1'b1;
    end
  end

  assign dhit = req && (cnt == DHIT_CNT_W'(DHIT_LATENCY));

  // Write enabled bytes on the hit cycle
  always_ff @(posedge CLK) begin
    if (wen && dhit) begin
      for (int b = 0; b < 4; b++) begin
        if (byte_ena[b]) begin
          mem[word_idx][8*b +: 8] <= wdata[8*b +: 8];
        end
      end
    end
  end

  assign rdata = mem[word_idx];

endmodule

// ==== source/rv32v_mem_pkg.sv ====
// Shared types for the vector memory stage; VLEN, RAM depth and hit latency are fixed here
package rv32v_mem_pkg;

  // Vector register length in bits
  localparam int unsigned VLEN = 128;

  // Data RAM depth in words and its word index width
  localparam int unsigned RAM_WORDS = 256;
  localparam int unsigned RAM_AW = $clog2(RAM_WORDS);

  // Cycles from a request to its hit
  localparam int unsigned DHIT_LATENCY = 2;
  localparam int unsigned DHIT_CNT_W = $clog2(DHIT_LATENCY + 1);

  // Data word, also used for addresses
  typedef logic [31:0] word_t;

  // Byte enables of one word access
  typedef logic [3:0] byte_ena_t;

  // Element width code: 0 = 8 bit, 1 = 16 bit, 2 = 32 bit
  typedef logic [1:0] eew_t;

  // Register group multiplier code: 0..3 stand for 1, 2, 4, 8
  typedef logic [1:0] vlmul_t;

  // Vector register index
  typedef logic [4:0] vreg_t;

  // Element offset within a register group
  typedef logic [4:0] woffset_t;

  // Vector length
  typedef logic [31:0] vl_t;

  // Scheduler FSM
  typedef enum logic [1:0] {
    IDLE,
    LANE0,
    LANE1,
    DONE
  } sched_state_t;

endpackage

// ==== source/rv32v_memory_stage.sv ====
// Memory stage without a hazard unit; busy stalls the writeback latch and flush clears it
module rv32v_memory_stage
  import rv32v_mem_pkg::*;
(
  input  logic         CLK,
  input  logic         nRST,
  input  logic         flush,
  // Execute side
  input  logic         ena,
  input  logic         load_ena,
  input  logic         store_ena,
  input  logic         config_ena,
  input  eew_t         eew,
  input  logic [1:0]   lane_wen,
  input  word_t        aluresult0,
  input  word_t        aluresult1,
  input  word_t        storedata0,
  input  word_t        storedata1,
  input  woffset_t     woffset0,
  input  woffset_t     woffset1,
  input  vreg_t        vd,
  input  logic         rd_wen,
  input  logic [4:0]   rd_sel,
  input  word_t        rd_data,
  input  vl_t          avl,
  input  word_t        next_vtype,
  // From scheduler and RAM
  input  word_t        dmemload,
  input  logic         arrived0,
  input  logic         busy,
  input  logic         exception,
  // To scheduler
  output logic         as_start,
  output logic         as_load_ena,
  output logic         as_store_ena,
  output eew_t         as_eew,
  output logic [1:0]   as_lane_wen,
  output word_t        as_addr0,
  output word_t        as_addr1,
  output word_t        as_storedata0,
  output word_t        as_storedata1,
  // Writeback latch
  output logic         wb_ena,
  output word_t        wb_wdat0,
  output word_t        wb_wdat1,
  output logic [1:0]   wb_wen,
  output woffset_t     wb_woffset0,
  output woffset_t     wb_woffset1,
  output vreg_t        wb_vd,
  output logic         wb_rd_wen,
  output logic [4:0]   wb_rd_sel,
  output word_t        wb_rd_data,
  // Vector configuration
  output vl_t          vl,
  output eew_t         sew,
  output vlmul_t       lmul
);

  word_t  data0;
  word_t  load0;
  word_t  wdat0;
  word_t  wdat1;
  eew_t   new_sew;
  vlmul_t new_lmul;
  vl_t    vlmax;
  vl_t    new_vl;
  logic   cfg_we;

  // Shift the addressed element down and clear bits above eew
  function automatic word_t align_load(word_t w, logic [1:0] off, eew_t e);
    word_t s;
    s = w >> {off, 3'b000};
    case (e)
      2'd0:    s = {24'd0, s[7:0]};
      2'd1:    s = {16'd0, s[15:0]};
      default: s = s;
    endcase
    return s;
  endfunction

  assign as_start      = ena && (load_ena || store_ena) && !flush;
  assign as_load_ena   = load_ena;
  assign as_store_ena  = store_ena;
  assign as_eew        = eew;
  assign as_lane_wen   = lane_wen;
  assign as_addr0      = aluresult0;
  assign as_addr1      = aluresult1;
  assign as_storedata0 = storedata0;
  assign as_storedata1 = storedata1;

  // Lane 0 buffer, bypassed when lane 0 is also the last hit
  always_ff @(posedge CLK) begin
    if (arrived0) begin
      data0 <= dmemload;
    end
  end

  assign load0 = arrived0 ? dmemload : data0;

  assign wdat0 = load_ena ? align_load(load0, aluresult0[1:0], eew) : aluresult0;
  assign wdat1 = load_ena ? align_load(dmemload, aluresult1[1:0], eew) : aluresult1;

  // VLMAX = VLEN / (8 << sew) * (1 << lmul)
  assign new_sew  = next_vtype[1:0];
  assign new_lmul = next_vtype[4:3];
  assign vlmax    = (vl_t'(VLEN) >> (3 + new_sew)) << new_lmul;
  assign new_vl   = (avl < vlmax) ? avl : vlmax;
  assign cfg_we   = ena && config_ena && !flush;

  // Latch control
  always_ff @(posedge CLK, negedge nRST) begin
    if (!nRST) begin
      wb_ena    <= 1'b0;
      wb_wen    <= 2'b00;
      wb_rd_wen <= 1'b0;
    end else if (flush) begin
      wb_ena    <= 1'b0;
      wb_wen    <= 2'b00;
      wb_rd_wen <= 1'b0;
    end else if (!busy) begin
      wb_ena    <= ena;
      wb_wen    <= exception ? 2'b00 : lane_wen;
      wb_rd_wen <= rd_wen;
    end
  end

  // Latch payload
  always_ff @(posedge CLK) begin
    if (flush) begin
      wb_wdat0    <= '0;
      wb_wdat1    <= '0;
      wb_woffset0 <= '0;
      wb_woffset1 <= '0;
      wb_vd       <= '0;
      wb_rd_sel   <= '0;
      wb_rd_data  <= '0;
    end else if (!busy) begin
      wb_wdat0    <= wdat0;
      wb_wdat1    <= wdat1;
      wb_woffset0 <= woffset0;
      wb_woffset1 <= woffset1;
      wb_vd       <= vd;
      wb_rd_sel   <= rd_sel;
      // vsetvl returns the granted vl to rd
      wb_rd_data  <= config_ena ? new_vl : rd_data;
    end
  end

  // vl and vtype
  always_ff @(posedge CLK, negedge nRST) begin
    if (!nRST) begin
      vl   <= '0;
      sew  <= '0;
      lmul <= '0;
    end else if (cfg_we) begin
      vl   <= new_vl;
      sew  <= new_sew;
      lmul <= new_lmul;
    end
  end

endmodule

// ==== source/rv32v_memory_subsystem.sv ====
// Memory stage, scheduler and RAM joined; execute inputs must stay steady while busy is high
module rv32v_memory_subsystem
  import rv32v_mem_pkg::*;
(
  input  logic         CLK,
  input  logic         nRST,
  input  logic         flush,
  input  logic         ena,
  input  logic         load_ena,
  input  logic         store_ena,
  input  logic         config_ena,
  input  eew_t         eew,
  input  logic [1:0]   lane_wen,
  input  word_t        aluresult0,
  input  word_t        aluresult1,
  input  word_t        storedata0,
  input  word_t        storedata1,
  input  woffset_t     woffset0,
  input  woffset_t     woffset1,
  input  vreg_t        vd,
  input  logic         rd_wen,
  input  logic [4:0]   rd_sel,
  input  word_t        rd_data,
  input  vl_t          avl,
  input  word_t        next_vtype,
  output logic         busy,
  output logic         exception,
  output logic         wb_ena,
  output word_t        wb_wdat0,
  output word_t        wb_wdat1,
  output logic [1:0]   wb_wen,
  output woffset_t     wb_woffset0,
  output woffset_t     wb_woffset1,
  output vreg_t        wb_vd,
  output logic         wb_rd_wen,
  output logic [4:0]   wb_rd_sel,
  output word_t        wb_rd_data,
  output vl_t          vl,
  output eew_t         sew,
  output vlmul_t       lmul
);

  // Stage to scheduler
  logic       as_start;
  logic       as_load_ena;
  logic       as_store_ena;
  eew_t       as_eew;
  logic [1:0] as_lane_wen;
  word_t      as_addr0;
  word_t      as_addr1;
  word_t      as_storedata0;
  word_t      as_storedata1;
  logic       arrived0;

  // Scheduler to RAM and back
  logic       ren;
  logic       wen;
  byte_ena_t  byte_ena;
  word_t      final_addr;
  word_t      final_storedata;
  word_t      dmemload;
  logic       dhit;

  rv32v_memory_stage u_memory_stage (
    .CLK           (CLK),
    .nRST          (nRST),
    .flush         (flush),
    .ena           (ena),
    .load_ena      (load_ena),
    .store_ena     (store_ena),
    .config_ena    (config_ena),
    .eew           (eew),
    .lane_wen      (lane_wen),
    .aluresult0    (aluresult0),
    .aluresult1    (aluresult1),
    .storedata0    (storedata0),
    .storedata1    (storedata1),
    .woffset0      (woffset0),
    .woffset1      (woffset1),
    .vd            (vd),
    .rd_wen        (rd_wen),
    .rd_sel        (rd_sel),
    .rd_data       (rd_data),
    .avl           (avl),
    .next_vtype    (next_vtype),
    .dmemload      (dmemload),
    .arrived0      (arrived0),
    .busy          (busy),
    .exception     (exception),
    .as_start      (as_start),
    .as_load_ena   (as_load_ena),
    .as_store_ena  (as_store_ena),
    .as_eew        (as_eew),
    .as_lane_wen   (as_lane_wen),
    .as_addr0      (as_addr0),
    .as_addr1      (as_addr1),
    .as_storedata0 (as_storedata0),
    .as_storedata1 (as_storedata1),
    .wb_ena        (wb_ena),
    .wb_wdat0      (wb_wdat0),
    .wb_wdat1      (wb_wdat1),
    .wb_wen        (wb_wen),
    .wb_woffset0   (wb_woffset0),
    .wb_woffset1   (wb_woffset1),
    .wb_vd         (wb_vd),
    .wb_rd_wen     (wb_rd_wen),
    .wb_rd_sel     (wb_rd_sel),
    .wb_rd_data    (wb_rd_data),
    .vl            (vl),
    .sew           (sew),
    .lmul          (lmul)
  );

  address_scheduler u_address_scheduler (
    .CLK             (CLK),
    .nRST            (nRST),
    .start           (as_start),
    .load_ena        (as_load_ena),
    .store_ena       (as_store_ena),
    .eew             (as_eew),
    .lane_wen        (as_lane_wen),
    .addr0           (as_addr0),
    .addr1           (as_addr1),
    .storedata0      (as_storedata0),
    .storedata1      (as_storedata1),
    .dhit            (dhit),
    .ren             (ren),
    .wen             (wen),
    .byte_ena        (byte_ena),
    .final_addr      (final_addr),
    .final_storedata (final_storedata),
    .arrived0        (arrived0),
    .busy            (busy),
    .exception       (exception)
  );

  data_ram u_data_ram (
    .CLK      (CLK),
    .nRST     (nRST),
    .ren      (ren),
    .wen      (wen),
    .byte_ena (byte_ena),
    .addr     (final_addr),
    .wdata    (final_storedata),
    .rdata    (dmemload),
    .dhit     (dhit)
  );

endmodule

// ==== tests/tb_checks.svh ====
// Included inside the testbench module after the rv32v_mem_pkg import; holds the error counter
`ifndef TB_CHECKS_SVH
`define TB_CHECKS_SVH

int unsigned error_count;
word_t       lfsr_state;

// Fibonacci LFSR with taps 32, 22, 2, 1, stepped once per bit taken
function automatic word_t rand_bits(int unsigned n);
  word_t v;
  logic  fb;
  v = '0;
  for (int unsigned i = 0; i < n; i++) begin
    fb = lfsr_state[31] ^ lfsr_state[21] ^ lfsr_state[1] ^ lfsr_state[0];
    lfsr_state = {lfsr_state[30:0], fb};
    v = {v[30:0], fb};
  end
  return v;
endfunction

task automatic check_word(input string test, input string field, input word_t exp,
                          input word_t act);
  if (act !== exp) begin
    error_count++;
    $display("ERROR %s: %s expected %h, actual %h", test, field, exp, act);
  end
endtask

task automatic check_eew(input string test, input string field, input eew_t exp,
                         input eew_t act);
  if (act !== exp) begin
    error_count++;
    $display("ERROR %s: %s expected %0d, actual %0d", test, field, exp, act);
  end
endtask

task automatic check_lmul(input string test, input string field, input vlmul_t exp,
                          input vlmul_t act);
  if (act !== exp) begin
    error_count++;
    $display("ERROR %s: %s expected %0d, actual %0d", test, field, exp, act);
  end
endtask

task automatic check_bit(input string test, input string field, input logic exp,
                         input logic act);
  if (act !== exp) begin
    error_count++;
    $display("ERROR %s: %s expected %b, actual %b", test, field, exp, act);
  end
endtask

`endif

// ==== tests/tb_rv32v_memory_subsystem.sv ====
// Table is built at time zero against a byte-wise RAM model; sew code 3 is never configured
module tb_rv32v_memory_subsystem
  import rv32v_mem_pkg::*;
();

  localparam int unsigned CLK_PERIOD   = 100;
  localparam int unsigned DRIVE_DELAY  = 10;
  localparam int unsigned RESET_CYCLES = 5;
  localparam int unsigned ROW_CYCLES   = 20;

  logic       CLK;
  logic       nRST;
  logic       flush;
  logic       ena;
  logic       load_ena;
  logic       store_ena;
  logic       config_ena;
  eew_t       eew;
  logic [1:0] lane_wen;
  word_t      aluresult0;
  word_t      aluresult1;
  word_t      storedata0;
  word_t      storedata1;
  woffset_t   woffset0;
  woffset_t   woffset1;
  vreg_t      vd;
  logic       rd_wen;
  logic [4:0] rd_sel;
  word_t      rd_data;
  vl_t        avl;
  word_t      next_vtype;
  logic       busy;
  logic       exception;
  logic       wb_ena;
  word_t      wb_wdat0;
  word_t      wb_wdat1;
  logic [1:0] wb_wen;
  woffset_t   wb_woffset0;
  woffset_t   wb_woffset1;
  vreg_t      wb_vd;
  logic       wb_rd_wen;
  logic [4:0] wb_rd_sel;
  word_t      wb_rd_data;
  vl_t        vl;
  eew_t       sew;
  vlmul_t     lmul;

  // One table row with stimulus first and expected values after
  typedef struct packed {
    logic       ena;
    logic       load;
    logic       store;
    logic       cfg;
    logic       flush;
    eew_t       eew;
    logic [1:0] lane_wen;
    word_t      a0;
    word_t      a1;
    word_t      sd0;
    word_t      sd1;
    woffset_t   wo0;
    woffset_t   wo1;
    vreg_t      vd;
    logic       rd_wen;
    logic [4:0] rd_sel;
    word_t      rd_data;
    vl_t        avl;
    word_t      vtype;
    logic       exc;
    logic       wb_ena_exp;
    logic [1:0] wen_exp;
    logic       rd_wen_exp;
    logic       chk_meta;
    logic       chk0;
    logic       chk1;
    word_t      wdat0;
    word_t      wdat1;
    word_t      rd_exp;
    vl_t        vl_exp;
    eew_t       sew_exp;
    vlmul_t     lmul_exp;
  } op_t;

  op_t        ops[$];
  string      names[$];
  logic       table_ready;
  logic       next_flush;
  logic [7:0] shadow [RAM_WORDS*4];
  vl_t        cur_vl;
  eew_t       cur_sew;
  vlmul_t     cur_lmul;

  `include "tb_checks.svh"

  rv32v_memory_subsystem u_rv32v_memory_subsystem (.*);

  initial begin
    CLK = 1'b0;
    forever #(CLK_PERIOD / 2) CLK = ~CLK;
  end

  function automatic int unsigned elem_bytes(eew_t e);
    return (e == 2'd0) ? 1 : ((e == 2'd1) ? 2 : 4);
  endfunction

  function automatic logic misaligned(eew_t e, word_t a);
    return (e == 2'd1) ? a[0] : ((e == 2'd2) ? (a[1:0] != 2'b00) : 1'b0);
  endfunction

  function automatic word_t rand_addr(eew_t e);
    word_t a;
    a = rand_bits(32);
    if (e == 2'd1) a[0] = 1'b0;
    if (e == 2'd2) a[1:0] = 2'b00;
    return a;
  endfunction

  // RAM only decodes bits [9:2] and the model keys on the low ten bits
  function automatic int unsigned byte_index(word_t a);
    return 32'(a[RAM_AW+1:0]);
  endfunction

  task automatic write_shadow(input eew_t e, input word_t a, input word_t d);
    for (int unsigned k = 0; k < elem_bytes(e); k++) begin
      shadow[byte_index(a) + k] = d[8*k +: 8];
    end
  endtask

  function automatic word_t read_shadow(eew_t e, word_t a);
    word_t v;
    v = '0;
    for (int unsigned k = 0; k < elem_bytes(e); k++) begin
      v[8*k +: 8] = shadow[byte_index(a) + k];
    end
    return v;
  endfunction

  function automatic vl_t expected_vl(eew_t s, vlmul_t m, vl_t req);
    int unsigned vlmax;
    vlmax = (VLEN / (8 * (2 ** s))) * (2 ** m);
    return (req < vlmax) ? req : vl_t'(vlmax);
  endfunction

  function automatic op_t new_op();
    op_t op;
    op = '0;
    op.ena        = 1'b1;
    op.flush      = next_flush;
    op.rd_wen     = 1'(rand_bits(1));
    op.wo0        = woffset_t'(rand_bits(5));
    op.wo1        = woffset_t'(rand_bits(5));
    op.vd         = vreg_t'(rand_bits(5));
    op.rd_sel     = 5'(rand_bits(5));
    op.rd_data    = rand_bits(32);
    op.a0         = rand_bits(32);
    op.a1         = rand_bits(32);
    op.wb_ena_exp = 1'b1;
    op.rd_wen_exp = op.rd_wen;
    op.rd_exp     = op.rd_data;
    op.chk_meta   = 1'b1;
    op.vl_exp     = cur_vl;
    op.sew_exp    = cur_sew;
    op.lmul_exp   = cur_lmul;
    return op;
  endfunction

  // A flushed row leaves an empty latch behind
  task automatic push_op(input string name, input op_t op);
    if (op.flush) begin
      op.exc        = 1'b0;
      op.wb_ena_exp = 1'b0;
      op.wen_exp    = 2'b00;
      op.rd_wen_exp = 1'b0;
      op.chk_meta   = 1'b0;
      op.chk0       = 1'b0;
      op.chk1       = 1'b0;
    end
    ops.push_back(op);
    names.push_back(name);
  endtask

  task automatic add_alu(input string name);
    op_t op;
    op = new_op();
    op.lane_wen = 2'(rand_bits(2));
    op.wen_exp  = op.lane_wen;
    op.wdat0    = op.a0;
    op.wdat1    = op.a1;
    op.chk0     = 1'b1;
    op.chk1     = 1'b1;
    push_op(name, op);
  endtask

  task automatic add_store(input string name, input eew_t e, input logic [1:0] lanes,
                           input word_t a0, input word_t a1, input word_t d0, input word_t d1);
    op_t op;
    op = new_op();
    op.store    = 1'b1;
    op.eew      = e;
    op.lane_wen = lanes;
    op.a0       = a0;
    op.a1       = a1;
    op.sd0      = d0;
    op.sd1      = d1;
    op.exc      = (lanes[0] && misaligned(e, a0)) || (lanes[1] && misaligned(e, a1));
    op.wen_exp  = op.exc ? 2'b00 : lanes;
    op.wdat0    = a0;
    op.wdat1    = a1;
    op.chk0     = 1'b1;
    op.chk1     = 1'b1;
    // Lane 1 lands after lane 0
    if (!op.flush && !op.exc) begin
      if (lanes[0]) write_shadow(e, a0, d0);
      if (lanes[1]) write_shadow(e, a1, d1);
    end
    push_op(name, op);
  endtask

  task automatic add_load(input string name, input eew_t e, input logic [1:0] lanes,
                          input word_t a0, input word_t a1);
    op_t op;
    op = new_op();
    op.load     = 1'b1;
    op.eew      = e;
    op.lane_wen = lanes;
    op.a0       = a0;
    op.a1       = a1;
    op.wen_exp  = lanes;
    op.wdat0    = read_shadow(e, a0);
    op.wdat1    = read_shadow(e, a1);
    op.chk0     = lanes[0];
    op.chk1     = lanes[1];
    push_op(name, op);
  endtask

  task automatic add_config(input string name, input eew_t s, input vlmul_t m, input vl_t req);
    op_t op;
    op = new_op();
    op.cfg   = 1'b1;
    op.avl   = req;
    op.vtype = {27'd0, m, 1'b0, s};
    op.wdat0 = op.a0;
    op.wdat1 = op.a1;
    op.chk0  = 1'b1;
    op.chk1  = 1'b1;
    op.rd_exp = expected_vl(s, m, req);
    if (!op.flush) begin
      cur_vl   = op.rd_exp;
      cur_sew  = s;
      cur_lmul = m;
    end
    op.vl_exp   = cur_vl;
    op.sew_exp  = cur_sew;
    op.lmul_exp = cur_lmul;
    push_op(name, op);
  endtask

  task automatic drive_idle();
    flush      = 1'b0;
    ena        = 1'b0;
    load_ena   = 1'b0;
    store_ena  = 1'b0;
    config_ena = 1'b0;
    eew        = '0;
    lane_wen   = '0;
    aluresult0 = '0;
    aluresult1 = '0;
    storedata0 = '0;
    storedata1 = '0;
    woffset0   = '0;
    woffset1   = '0;
    vd         = '0;
    rd_wen     = 1'b0;
    rd_sel     = '0;
    rd_data    = '0;
    avl        = '0;
    next_vtype = '0;
  endtask

  task automatic apply_row(input op_t op);
    flush      = op.flush;
    ena        = op.ena;
    load_ena   = op.load;
    store_ena  = op.store;
    config_ena = op.cfg;
    eew        = op.eew;
    lane_wen   = op.lane_wen;
    aluresult0 = op.a0;
    aluresult1 = op.a1;
    storedata0 = op.sd0;
    storedata1 = op.sd1;
    woffset0   = op.wo0;
    woffset1   = op.wo1;
    vd         = op.vd;
    rd_wen     = op.rd_wen;
    rd_sel     = op.rd_sel;
    rd_data    = op.rd_data;
    avl        = op.avl;
    next_vtype = op.vtype;
  endtask

  // Accepting cycle first, then the latching edge follows the first falling edge with busy low
  task automatic wait_for_latch(input op_t op, input string name);
    logic mem_op;
    mem_op = op.ena && (op.load || op.store) && !op.exc && !op.flush;
    @(negedge CLK);
    check_bit(name, "exception", op.exc, exception);
    check_bit(name, "busy", mem_op, busy);
    while (busy) begin
      @(negedge CLK);
    end
  endtask

  task automatic check_row(input op_t op, input string name);
    check_bit(name, "wb_ena", op.wb_ena_exp, wb_ena);
    check_bit(name, "wb_wen[0]", op.wen_exp[0], wb_wen[0]);
    check_bit(name, "wb_wen[1]", op.wen_exp[1], wb_wen[1]);
    check_bit(name, "wb_rd_wen", op.rd_wen_exp, wb_rd_wen);
    if (op.chk_meta) begin
      check_word(name, "wb_woffset0", word_t'(op.wo0), word_t'(wb_woffset0));
      check_word(name, "wb_woffset1", word_t'(op.wo1), word_t'(wb_woffset1));
      check_word(name, "wb_vd", word_t'(op.vd), word_t'(wb_vd));
      check_word(name, "wb_rd_sel", word_t'(op.rd_sel), word_t'(wb_rd_sel));
      check_word(name, "wb_rd_data", op.rd_exp, wb_rd_data);
    end
    if (op.chk0) check_word(name, "wb_wdat0", op.wdat0, wb_wdat0);
    if (op.chk1) check_word(name, "wb_wdat1", op.wdat1, wb_wdat1);
    check_word(name, "vl", op.vl_exp, vl);
    check_eew(name, "sew", op.sew_exp, sew);
    check_lmul(name, "lmul", op.lmul_exp, lmul);
  endtask

  initial begin
    word_t a;
    word_t b;
    word_t c;
    table_ready = 1'b0;
    next_flush  = 1'b0;
    error_count = 0;
    lfsr_state  = 32'h5adf4a31;
    cur_vl      = '0;
    cur_sew     = '0;
    cur_lmul    = '0;
    nRST        = 1'b0;
    drive_idle();
    for (int i = 0; i < RAM_WORDS * 4; i++) begin
      shadow[i] = 8'h00;
    end

    add_alu("alu_0");
    add_alu("alu_1");
    add_alu("alu_2");
    // Every width on each lane mix with an immediate read back
    for (int e = 0; e < 3; e++) begin
      for (int l = 1; l < 4; l++) begin
        a = rand_addr(eew_t'(e));
        b = rand_addr(eew_t'(e));
        add_store($sformatf("store_e%0d_l%0d", e, l), eew_t'(e), 2'(l), a, b,
                  rand_bits(32), rand_bits(32));
        add_load($sformatf("load_e%0d_l%0d", e, l), eew_t'(e), 2'(l), a, b);
      end
    end
    // Partial writes into one word
    a = rand_addr(2'd2);
    add_store("merge_word", 2'd2, 2'b01, a, a, rand_bits(32), rand_bits(32));
    add_store("merge_byte", 2'd0, 2'b01, a + 1, a, rand_bits(32), rand_bits(32));
    add_store("merge_half", 2'd1, 2'b10, a, a + 2, rand_bits(32), rand_bits(32));
    add_load("merge_load_word", 2'd2, 2'b01, a, a);
    add_load("merge_load_bytes", 2'd0, 2'b11, a + 1, a + 3);
    add_load("merge_load_halves", 2'd1, 2'b11, a, a + 2);
    // Misaligned stores must leave memory alone
    b = rand_addr(2'd2);
    add_store("misalign_setup", 2'd2, 2'b11, b, b + 4, rand_bits(32), rand_bits(32));
    add_store("misalign_half", 2'd1, 2'b01, b + 1, b, rand_bits(32), rand_bits(32));
    add_store("misalign_word", 2'd2, 2'b11, b + 4, b + 2, rand_bits(32), rand_bits(32));
    add_load("misalign_check", 2'd2, 2'b11, b, b + 4);
    add_config("config_e8_m1", 2'd0, 2'd0, 32'd5);
    add_config("config_e8_m8", 2'd0, 2'd3, 32'd1000);
    add_config("config_e16_m2", 2'd1, 2'd1, 32'd3);
    add_config("config_e32_m4", 2'd2, 2'd2, 32'd100);
    add_config("config_e32_m1", 2'd2, 2'd0, 32'd4);
    add_config("config_e16_m8", 2'd1, 2'd3, 32'd0);
    add_config("config_e16_m4", 2'd1, 2'd2, 32'd7);
    c = rand_addr(2'd2);
    add_store("flush_setup", 2'd2, 2'b11, c, c + 4, rand_bits(32), rand_bits(32));
    next_flush = 1'b1;
    add_alu("flush_alu");
    add_store("flush_store", 2'd2, 2'b11, c, c + 4, rand_bits(32), rand_bits(32));
    add_config("flush_config", 2'd0, 2'd3, 32'd99);
    next_flush = 1'b0;
    add_load("flush_check", 2'd2, 2'b11, c, c + 4);
    table_ready = 1'b1;

    repeat (RESET_CYCLES) @(posedge CLK);
    #DRIVE_DELAY;
    nRST = 1'b1;
    check_bit("reset", "busy", 1'b0, busy);
    check_bit("reset", "exception", 1'b0, exception);
    check_bit("reset", "wb_ena", 1'b0, wb_ena);
    check_word("reset", "wb_wen", '0, word_t'(wb_wen));
    check_word("reset", "vl", '0, vl);
    check_eew("reset", "sew", '0, sew);
    check_lmul("reset", "lmul", '0, lmul);

    for (int i = 0; i < ops.size(); i++) begin
      apply_row(ops[i]);
      wait_for_latch(ops[i], names[i]);
      @(posedge CLK);
      #DRIVE_DELAY;
      check_row(ops[i], names[i]);
    end
    drive_idle();

    $display("Summary: %0d rows applied, %0d errors", ops.size(), error_count);
    if (error_count == 0) begin
      $display("Simulation finished: PASS");
    end else begin
      $display("Simulation finished: FAIL");
    end
    $finish;
  end

  // Each row needs only a handful of cycles and ROW_CYCLES leaves slack
  initial begin
    wait (table_ready === 1'b1);
    repeat (ops.size() * ROW_CYCLES + RESET_CYCLES) @(posedge CLK);
    $display("Timeout: the operation table did not finish in %0d cycles",
             ops.size() * ROW_CYCLES + RESET_CYCLES);
    $display("Simulation finished: FAIL");
    $finish;
  end

endmodule
